/* Makefile */
# Verilator build and run of the cartridge testbench

VERILATOR ?= verilator
TOP       ?= cartBoardTb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

SRCS := $(wildcard design/*.sv design/*.svh dv/*.sv)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -qx "Simulation passed" $(LOG); then echo "PASS"; else echo "FAIL"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/cartBoardTop.sv */
`timescale 1ns/1ps
`include "cart_consts.svh"

module cartBoardTop (
    input  logic                    CLK,
    input  logic                    rstN,
    // MSX slot
    input  logic                    sltslN,
    input  logic                    rdN,
    input  logic                    wrN,
    input  logic [7:0]              busMux,
    output logic [`MUX_GROUPS-1:0]  muxCsN,
    input  logic [7:0]              dataIn,
    output logic [7:0]              dataOut,
    output logic                    dataOe,
    output logic                    busdirN,
    output logic                    intN,
    // Storage card
    output logic                    sclk,
    output logic                    mosi,
    input  logic                    miso,
    output logic                    spiCsN,
    // Sound
    output logic                    soundOut
);
    // Bus front end to registers
    logic               regRd;
    logic               regWr;
    cartPkg::regOffT    regOff;
    cartPkg::byteT      regWdata;
    cartPkg::byteT      regRdata;
    // Registers to SPI master
    logic               spiStart;
    cartPkg::byteT      txByte;
    logic               busy;
    cartPkg::byteT      rxByte;
    // Registers to DAC
    cartPkg::levelT     level;

    cartBus cartBus_i (
        .CLK,
        .rstN,
        .sltslN,
        .rdN,
        .wrN,
        .busMux,
        .muxCsN,
        .dataIn,
        .dataOut,
        .dataOe,
        .busdirN,
        .regRd,
        .regWr,
        .regOff,
        .regWdata,
        .regRdata
    );

    cartRegs cartRegs_i (
        .CLK,
        .rstN,
        .regRd,
        .regWr,
        .regOff,
        .regWdata,
        .regRdata,
        .spiStart,
        .txByte,
        .busy,
        .rxByte,
        .spiCsN,
        .level,
        .intN
    );

    spiMaster spiMaster_i (
        .CLK,
        .rstN,
        .spiStart,
        .txByte,
        .busy,
        .rxByte,
        .sclk,
        .mosi,
        .miso
    );

    deltaSigmaDac deltaSigmaDac_i (
        .CLK,
        .rstN,
        .level,
        .soundOut
    );

endmodule

/* design/cartBus.sv */
`timescale 1ns/1ps
`include "cart_consts.svh"

module cartBus (
    input  logic                    CLK,
    input  logic                    rstN,
    // Slot strobes, async to CLK
    input  logic                    sltslN,
    input  logic                    rdN,
    input  logic                    wrN,
    // Shared address mux pins
    input  cartPkg::byteT           busMux,
    output logic [`MUX_GROUPS-1:0]  muxCsN,
    // Split data bus, pad tristate lives on the board
    input  cartPkg::byteT           dataIn,
    output cartPkg::byteT           dataOut,
    output logic                    dataOe,
    output logic                    busdirN,
    // Register file side
    output logic                    regRd,
    output logic                    regWr,
    output cartPkg::regOffT         regOff,
    output cartPkg::byteT           regWdata,
    input  cartPkg::byteT           regRdata
);
    localparam int GROUPS = `MUX_GROUPS;
    localparam int GRP_W = (GROUPS > 1) ? $clog2(GROUPS) : 1;
    localparam int SPAN = `CART_REG_SPAN_BITS;
    localparam cartPkg::addrT REG_BASE = `CART_REG_BASE;

    logic [GRP_W-1:0]       grpCnt;
    logic [GRP_W-1:0]       nextGrp;
    logic [GROUPS-1:0]      nextCs;
    logic [GRP_W-1:0]       grpQ;
    cartPkg::byteT          muxQ;
    cartPkg::addrT          addrReg;
    // {sltslN, rdN, wrN}
    logic [2:0]             strbMeta;
    logic [2:0]             strbSync;
    logic                   slotRd;
    logic                   slotWr;
    logic                   accPrev;
    logic                   accStart;
    logic                   inWin;
    logic                   rdDly;

    // Next group to select, one-hot low
    always_comb begin
        nextGrp = (grpCnt == GRP_W'(GROUPS - 1)) ? '0 : grpCnt + 1'b1;
        nextCs = '1;
        nextCs[nextGrp] = 1'b0;
    end

    // Rotate the mux selects one group per cycle
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            grpCnt <= '0;
            muxCsN <= '1;
        end else begin
            grpCnt <= nextGrp;
            muxCsN <= nextCs;
        end
    end

    // Pad flop on the mux pins, tagged with the group that was selected
    // Byte lands in the address one cycle after its select
    always_ff @(posedge CLK) begin
        muxQ <= busMux;
        grpQ <= grpCnt;
        addrReg[{grpQ, 3'b000} +: 8] <= muxQ;
    end

    // Two-flop sync of the slot strobes, idle high
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            strbMeta <= 3'b111;
            strbSync <= 3'b111;
        end else begin
            strbMeta <= {sltslN, rdN, wrN};
            strbSync <= strbMeta;
        end
    end

    assign slotRd = ~strbSync[2] & ~strbSync[1];
    assign slotWr = ~strbSync[2] & ~strbSync[0];
    // First synchronized cycle of an access
    assign accStart = (slotRd | slotWr) & ~accPrev;
    // Upper address bits must hit the register window
    assign inWin = (addrReg[15:SPAN] == REG_BASE[15:SPAN]);

    // Register strobes, one cycle after the access start
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            accPrev <= 1'b0;
            regRd <= 1'b0;
            regWr <= 1'b0;
        end else begin
            accPrev <= slotRd | slotWr;
            regRd <= accStart & slotRd & inWin;
            // Read wins if both strobes show up together
            regWr <= accStart & slotWr & ~slotRd & inWin;
        end
    end

    // Offset and write data go with the strobe
    always_ff @(posedge CLK) begin
        if (accStart) begin
            regOff <= addrReg[SPAN-1:0];
            regWdata <= dataIn;
        end
    end

    // Read drive, opens two cycles after regRd
    // Held until the synced RD_n goes back high
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            rdDly <= 1'b0;
            dataOe <= 1'b0;
            busdirN <= 1'b1;
        end else begin
            rdDly <= regRd;
            if (rdDly) begin
                dataOe <= 1'b1;
                busdirN <= 1'b0;
            end else if (dataOe && strbSync[1]) begin
                dataOe <= 1'b0;
                busdirN <= 1'b1;
            end
        end
    end

    // Read data is ready in the cycle after regRd
    always_ff @(posedge CLK) begin
        if (rdDly) begin
            dataOut <= regRdata;
        end
    end

endmodule

/* design/cartPkg.sv */
`include "cart_consts.svh"

package cartPkg;

    // Full slot address as seen on the mux pins
    typedef logic [15:0] addrT;

    // Data byte on the slot bus and SPI
    typedef logic [7:0] byteT;

    // Register offset inside the window
    typedef logic [`CART_REG_SPAN_BITS-1:0] regOffT;

    // Sound level for the 1-bit DAC
    typedef logic [7:0] levelT;

    // SPI master phases
    // LOW and HIGH follow the SCLK level
    typedef enum logic [1:0] {
        IDLE,
        LOW,
        HIGH
    } spiStateT;

endpackage

/* design/cartRegs.sv */
`timescale 1ns/1ps

module cartRegs (
    input  logic                CLK,
    input  logic                rstN,
    // From the bus front end
    input  logic                regRd,
    input  logic                regWr,
    input  cartPkg::regOffT     regOff,
    input  cartPkg::byteT       regWdata,
    output cartPkg::byteT       regRdata,
    // SPI master control
    output logic                spiStart,
    output cartPkg::byteT       txByte,
    input  logic                busy,
    input  cartPkg::byteT       rxByte,
    output logic                spiCsN,
    // Sound level, held until rewritten
    output cartPkg::levelT      level,
    // Slot interrupt
    output logic                intN
);
    logic   intEn;
    logic   doneFlag;
    logic   busyQ;
    logic   busyFall;

    // Offset 0 write kicks a transfer, dropped while busy
    assign spiStart = regWr && (regOff == 2'd0) && !busy;
    assign txByte = regWdata;

    assign busyFall = busyQ & ~busy;

    // Control bits and sound level
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            spiCsN <= 1'b1;
            intEn <= 1'b0;
            level <= '0;
        end else if (regWr) begin
            case (regOff)
                2'd1: begin
                    spiCsN <= regWdata[0];
                    intEn <= regWdata[1];
                end
                2'd2: level <= regWdata;
                default: ;
            endcase
        end
    end

    // Done flag, set on busy falling and cleared by a status read
    // A set in the same cycle as the read is kept
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            busyQ <= 1'b0;
            doneFlag <= 1'b0;
        end else begin
            busyQ <= busy;
            if (busyFall) begin
                doneFlag <= 1'b1;
            end else if (regRd && (regOff == 2'd1)) begin
                doneFlag <= 1'b0;
            end
        end
    end

    // Registered read mux
    always_ff @(posedge CLK) begin
        if (regRd) begin
            case (regOff)
                2'd0: regRdata <= rxByte;
                2'd1: regRdata <= {busy, doneFlag, 4'b0000, intEn, spiCsN};
                2'd2: regRdata <= level;
                default: regRdata <= 8'hFF;
            endcase
        end
    end

    // Interrupt line, low while an enabled completion is pending
    assign intN = ~(doneFlag & intEn);

endmodule

/* design/cart_consts.svh */
`ifndef CART_CONSTS_SVH
`define CART_CONSTS_SVH

// Slot register window

// First register address in the slot
`define CART_REG_BASE 16'h7FF0
// Offset bits inside the window, 4 registers
`define CART_REG_SPAN_BITS 2

// SPI clocking

// CLK cycles per SCLK half period
`define SPI_HALF_PERIOD 3

// Address scan

// Byte groups behind the shared mux pins
// Group 0 carries A7..A0, group 1 carries A15..A8
`define MUX_GROUPS 2

`endif

/* design/deltaSigmaDac.sv */
`timescale 1ns/1ps

module deltaSigmaDac (
    input  logic            CLK,
    input  logic            rstN,
    input  cartPkg::levelT  level,
    output logic            soundOut
);
    cartPkg::levelT acc;
    // Carry in bit 8
    logic [8:0]     sum;

    assign sum = {1'b0, acc} + {1'b0, level};

    // First order loop
    // Carries per 256 cycles equal the level
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            acc <= '0;
            soundOut <= 1'b0;
        end else begin
            acc <= sum[7:0];
            soundOut <= sum[8];
        end
    end

endmodule

/* design/spiMaster.sv */
`timescale 1ns/1ps
`include "cart_consts.svh"

module spiMaster (
    input  logic            CLK,
    input  logic            rstN,
    input  logic            spiStart,
    input  cartPkg::byteT   txByte,
    output logic            busy,
    output cartPkg::byteT   rxByte,
    // Card pins, mode 0
    output logic            sclk,
    output logic            mosi,
    input  logic            miso
);
    localparam int HALF = `SPI_HALF_PERIOD;
    localparam int HALF_W = $clog2(HALF + 1);

    cartPkg::spiStateT      state;
    logic [HALF_W-1:0]      halfCnt;
    logic [2:0]             bitCnt;
    cartPkg::byteT          txShift;
    cartPkg::byteT          rxShift;
    logic                   halfDone;

    assign halfDone = (halfCnt == HALF_W'(HALF - 1));
    assign busy = (state != cartPkg::IDLE);
    // MSB first, shifted on falling SCLK
    assign mosi = txShift[7];

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            state <= cartPkg::IDLE;
            sclk <= 1'b0;
            halfCnt <= '0;
            bitCnt <= '0;
            txShift <= 8'hFF;
            rxByte <= '0;
        end else begin
            halfCnt <= halfDone ? '0 : halfCnt + 1'b1;
            case (state)
                cartPkg::IDLE: begin
                    halfCnt <= '0;
                    if (spiStart) begin
                        state <= cartPkg::LOW;
                        txShift <= txByte;
                        bitCnt <= '0;
                    end
                end
                cartPkg::LOW: begin
                    // Rising SCLK, sample the card
                    if (halfDone) begin
                        state <= cartPkg::HIGH;
                        sclk <= 1'b1;
                        rxShift <= {rxShift[6:0], miso};
                    end
                end
                cartPkg::HIGH: begin
                    // Falling SCLK, next bit or finish
                    if (halfDone) begin
                        sclk <= 1'b0;
                        txShift <= {txShift[6:0], 1'b1};
                        if (bitCnt == 3'd7) begin
                            state <= cartPkg::IDLE;
                            rxByte <= rxShift;
                        end else begin
                            state <= cartPkg::LOW;
                            bitCnt <= bitCnt + 1'b1;
                        end
                    end
                end
                default: state <= cartPkg::IDLE;
            endcase
        end
    end

endmodule

/* dv/cartBoardTb.sv */
`timescale 1ns/1ps
`include "cart_consts.svh"

module cartBoardTb;
    // 200 us of 10 ns cycles is about six times the expected run of 3500 cycles
    localparam int RUN_CYCLES = 20000;
    localparam int SPI_CYCLES = 16 * `SPI_HALF_PERIOD + 1;
    localparam logic [15:0] BASE = `CART_REG_BASE;

    logic                   CLK;
    logic                   rstN;
    logic                   sltslN;
    logic                   rdN;
    logic                   wrN;
    logic [15:0]            busAddr;
    logic [7:0]             busMux;
    logic [`MUX_GROUPS-1:0] muxCsN;
    logic [7:0]             dataIn;
    logic [7:0]             dataOut;
    logic                   dataOe;
    logic                   busdirN;
    logic                   intN;
    logic                   sclk;
    logic                   mosi;
    logic                   miso;
    logic                   spiCsN;
    logic                   soundOut;

    // Card model state
    logic [7:0] cardResp;
    logic [7:0] cardIn = 8'h00;
    int         cardBits = 0;
    int         outBits = 0;

    // Register model
    logic [7:0] mLevel;
    logic [7:0] mRx;
    logic       mCsN;
    logic       mIntEn;
    logic       mDone;

    logic [31:0] rngState;
    int          errors;
    int          checks;
    int          testBase;
    // Owned by the compare process
    int          cmpErrors = 0;
    int          cmpChecks = 0;
    string       cmpWhat;
    logic [7:0]  cmpGot;
    logic [7:0]  cmpExp;
    // Pending reads for the compare process
    logic [7:0]  gotQ[$];
    logic [7:0]  expQ[$];
    string       nameQ[$];

    cartBoardTop cartBoardTop_i (.*);

    // The selected group puts its address byte on the mux pins
    assign busMux = !muxCsN[0] ? busAddr[7:0] : (!muxCsN[1] ? busAddr[15:8] : 8'hFF);

    // SPI card in mode 0 with the response sent MSB first
    assign miso = cardResp[3'd7 - outBits[2:0]];

    always @(posedge sclk) begin
        cardIn <= {cardIn[6:0], mosi};
        cardBits <= cardBits + 1;
    end

    // Next response bit goes out on falling SCLK
    always @(negedge sclk) begin
        outBits <= cardBits;
    end

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // Expected register contents while busy is 0 as in every checked read
    function automatic logic [7:0] expRead(input logic [1:0] off);
        case (off)
            2'd0: return mRx;
            2'd1: return {1'b0, mDone, 4'b0000, mIntEn, mCsN};
            2'd2: return mLevel;
            default: return 8'hFF;
        endcase
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] randWord();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    // Compares each read that the bus tasks queue up
    always @(posedge CLK) begin
        while (gotQ.size() > 0) begin
            cmpWhat = nameQ.pop_front();
            cmpGot = gotQ.pop_front();
            cmpExp = expQ.pop_front();
            cmpChecks++;
            if (cmpGot !== cmpExp) begin
                $display("Error %s: dataOut 0x%02h, expected 0x%02h", cmpWhat, cmpGot, cmpExp);
                cmpErrors++;
            end
        end
    end

    task automatic expectBit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("Error %s: 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    // One slot cycle with the address set first and 10 cycles of strobe
    task automatic slotAccess(input logic [15:0] addr, input logic isRd,
                              input logic [7:0] wdata, output logic [7:0] rdata,
                              output logic oeEnd, output logic dirEnd, output logic sawOe);
        @(negedge CLK);
        busAddr = addr;
        dataIn = wdata;
        // Let the scan pick up both address bytes
        repeat (8) @(negedge CLK);
        sltslN = 1'b0;
        if (isRd) begin
            rdN = 1'b0;
        end else begin
            wrN = 1'b0;
        end
        sawOe = 1'b0;
        repeat (10) begin
            @(negedge CLK);
            if (dataOe) begin
                sawOe = 1'b1;
            end
        end
        rdata = dataOut;
        oeEnd = dataOe;
        dirEnd = busdirN;
        sltslN = 1'b1;
        rdN = 1'b1;
        wrN = 1'b1;
        // Drive drops three cycles after RD_n rises
        repeat (4) @(negedge CLK);
        expectBit("dataOe after the strobe", dataOe, 1'b0);
        expectBit("busdirN after the strobe", busdirN, 1'b1);
    endtask

    task automatic regWrite(input logic [1:0] off, input logic [7:0] val);
        logic [7:0] unused;
        logic       oe;
        logic       dir;
        logic       saw;
        slotAccess({BASE[15:2], off}, 1'b0, val, unused, oe, dir, saw);
    endtask

    task automatic rawRead(input logic [1:0] off, output logic [7:0] val);
        logic oe;
        logic dir;
        logic saw;
        slotAccess({BASE[15:2], off}, 1'b1, 8'h00, val, oe, dir, saw);
    endtask

    // Window read whose value goes to the compare process
    task automatic checkRead(input logic [1:0] off, input string what);
        logic [7:0] got;
        logic       oe;
        logic       dir;
        logic       saw;
        slotAccess({BASE[15:2], off}, 1'b1, 8'h00, got, oe, dir, saw);
        expectBit({what, " dataOe"}, oe, 1'b1);
        expectBit({what, " busdirN"}, dir, 1'b0);
        gotQ.push_back(got);
        expQ.push_back(expRead(off));
        nameQ.push_back(what);
    endtask

    // Poll status until busy clears and read once more to clear a late done
    task automatic waitSpiIdle();
        logic [7:0] st;
        int         polls;
        polls = 0;
        st = 8'h80;
        while (st[7] && polls < 20) begin
            rawRead(2'd1, st);
            polls++;
        end
        checks++;
        if (st[7]) begin
            $display("SPI busy still set after %0d status reads", polls);
            errors++;
        end
        rawRead(2'd1, st);
        mDone = 1'b0;
    endtask

    task automatic finishTest(input string name);
        @(posedge CLK);
        @(negedge CLK);
        $display("%s: %0d errors", name, errors + cmpErrors - testBase);
        testBase = errors + cmpErrors;
    endtask

    initial begin
        logic [31:0] r;
        logic [15:0] a;
        logic [7:0]  tx;
        logic [7:0]  got;
        logic        oe;
        logic        dir;
        logic        saw;
        int          bitsBefore;
        int          n;
        int          hi;
        logic        sawLow;

        rstN = 1'b0;
        sltslN = 1'b1;
        rdN = 1'b1;
        wrN = 1'b1;
        busAddr = 16'h0000;
        dataIn = 8'h00;
        cardResp = 8'hFF;
        rngState = 32'ha4ab_e18b;
        errors = 0;
        checks = 0;
        testBase = 0;
        mLevel = 8'h00;
        mRx = 8'h00;
        mCsN = 1'b1;
        mIntEn = 1'b0;
        mDone = 1'b0;
        repeat (10) @(negedge CLK);
        rstN = 1'b1;
        repeat (2) @(negedge CLK);

        expectBit("dataOe", dataOe, 1'b0);
        expectBit("busdirN", busdirN, 1'b1);
        expectBit("intN", intN, 1'b1);
        expectBit("spiCsN", spiCsN, 1'b1);
        finishTest("Test 1 reset state");

        for (int i = 0; i < 6; i++) begin
            r = randWord();
            regWrite(2'd2, r[7:0]);
            mLevel = r[7:0];
            // Done is clear here and intN stays high whatever the enable
            regWrite(2'd1, {6'b000000, r[9:8]});
            mCsN = r[8];
            mIntEn = r[9];
            checkRead(2'd2, "level");
            checkRead(2'd1, "control");
            regWrite(2'd3, r[23:16]);
            checkRead(2'd3, "spare");
        end
        finishTest("Test 2 register readback");

        for (int i = 0; i < 8; i++) begin
            r = randWord();
            a = r[15:0];
            if (a[15:2] == BASE[15:2]) begin
                a[15] = ~a[15];
            end
            slotAccess(a, r[16], r[31:24], got, oe, dir, saw);
            checks++;
            if (saw) begin
                $display("Data drive came on for address %04h outside the window", a);
                errors++;
            end
        end
        for (int k = 0; k < 4; k++) begin
            checkRead(k[1:0], "after outside access");
        end
        finishTest("Test 3 outside window");

        regWrite(2'd1, 8'h00);
        mCsN = 1'b0;
        mIntEn = 1'b0;
        expectBit("spiCsN", spiCsN, 1'b0);
        for (int i = 0; i < 4; i++) begin
            r = randWord();
            tx = r[7:0];
            cardResp = r[15:8];
            bitsBefore = cardBits;
            regWrite(2'd0, tx);
            // Lands well inside the 49 cycle transfer
            if (i[0]) begin
                regWrite(2'd0, ~tx);
            end
            waitSpiIdle();
            checks++;
            if (cardBits - bitsBefore != 8) begin
                $display("Error sclk: rising edges 0x%0h, expected 0x8", cardBits - bitsBefore);
                errors++;
            end
            checks++;
            if (cardIn !== tx) begin
                $display("Error card: cardIn 0x%02h, expected 0x%02h", cardIn, tx);
                errors++;
            end
            mRx = cardResp;
            checkRead(2'd0, "spi rx");
        end
        finishTest("Test 4 SPI transfers");

        regWrite(2'd1, 8'h02);
        mIntEn = 1'b1;
        r = randWord();
        cardResp = r[7:0];
        regWrite(2'd0, r[15:8]);
        n = 0;
        while (intN && n < 2 * SPI_CYCLES) begin
            @(negedge CLK);
            n++;
        end
        checks++;
        if (intN) begin
            $display("Interrupt did not come after the transfer with the enable set");
            errors++;
        end
        mDone = 1'b1;
        mRx = cardResp;
        checkRead(2'd1, "status with done");
        mDone = 1'b0;
        expectBit("intN after status read", intN, 1'b1);
        checkRead(2'd0, "rx with interrupt");
        regWrite(2'd1, 8'h00);
        mIntEn = 1'b0;
        r = randWord();
        cardResp = r[7:0];
        regWrite(2'd0, r[15:8]);
        sawLow = 1'b0;
        repeat (2 * SPI_CYCLES) begin
            @(negedge CLK);
            if (!intN) begin
                sawLow = 1'b1;
            end
        end
        checks++;
        if (sawLow) begin
            $display("Interrupt came with the enable cleared");
            errors++;
        end
        waitSpiIdle();
        mRx = cardResp;
        checkRead(2'd0, "rx without interrupt");
        finishTest("Test 5 interrupt");

        for (int i = 0; i < 4; i++) begin
            r = randWord();
            regWrite(2'd2, r[7:0]);
            mLevel = r[7:0];
            repeat (4) @(negedge CLK);
            hi = 0;
            repeat (256) begin
                @(negedge CLK);
                if (soundOut) begin
                    hi++;
                end
            end
            checks++;
            if (hi != int'(r[7:0])) begin
                $display("Error soundOut: high count 0x%02h, expected 0x%02h", hi, r[7:0]);
                errors++;
            end
        end
        finishTest("Test 6 sound density");

        $display("Checks %0d, errors %0d", checks + cmpChecks, errors + cmpErrors);
        if (errors + cmpErrors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (RUN_CYCLES) @(posedge CLK);
        $display("Watchdog expired after %0d cycles before the tests finished", RUN_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+design
design/cartPkg.sv
design/cartBus.sv
design/cartRegs.sv
design/spiMaster.sv
design/deltaSigmaDac.sv
design/cartBoardTop.sv
dv/cartBoardTb.sv
